//--- fpu_fmt_pkg.sv
// single-precision format widths, special encodings and the result-word union
package fpu_fmt_pkg;

  ////////////////////
  // field widths
  ////////////////////

  localparam int EXP_W     = 10;  // internal exponent, two bits of headroom
  localparam int FRAC_IN_W = 28;  // incoming fraction with round and sticky tail
  localparam int MANT_W    = 24;  // mantissa incl hidden bit
  localparam int SHIFT_W   = 5;   // align shift amount
  localparam int WORD_W    = 32;  // packed result word

  // largest biased exponent below infinity
  localparam logic [EXP_W-1:0] EXP_MAX = 10'd254;

  ////////////////////
  // special bodies
  ////////////////////

  // everything below the sign bit
  localparam logic [30:0] INF_BODY  = 31'h7F80_0000; // exp all ones, frac zero
  localparam logic [30:0] QNAN_BODY = 31'h7FC0_0000; // quiet bit set
  localparam logic [30:0] SNAN_BODY = 31'h7FBF_FFFF; // quiet bit clear, rest ones

  ////////////////////
  // result word
  ////////////////////

  // one 32-bit word, read as ieee float or as a signed integer
  typedef union packed {
    struct packed {
      logic        sign;
      logic [7:0]  exp;   // biased
      logic [22:0] frac;  // hidden bit dropped
    } f;
    logic signed [WORD_W-1:0] i;  // f2i result
  } fpu_word_u;

endpackage

//--- fpu_ctrl_pkg.sv
// rounding-mode codes, rounding decision and flag-vector bit positions
package fpu_ctrl_pkg;

  // rounding modes, 2-bit codes
  localparam logic [1:0] RM_NEAREST = 2'd0;  // ties to even
  localparam logic [1:0] RM_TO_ZERO = 2'd1;  // truncate
  localparam logic [1:0] RM_TO_INFP = 2'd2;  // toward +inf
  localparam logic [1:0] RM_TO_INFM = 2'd3;  // toward -inf

  ////////////////////
  // exception flags
  ////////////////////

  localparam int FLAG_W  = 8;
  localparam int FLG_OVF = 0;  // overflow
  localparam int FLG_UNF = 1;  // underflow
  localparam int FLG_SNF = 2;  // signaling nan
  localparam int FLG_QNF = 3;  // quiet nan
  localparam int FLG_ZF  = 4;  // zero result
  localparam int FLG_IXF = 5;  // inexact
  localparam int FLG_IVF = 6;  // invalid
  localparam int FLG_INF = 7;  // infinity

  // add-one decision, common to both round stages
  // g is the lsb kept, r the first bit dropped, s the or of the rest
  function automatic logic round_up(input logic [1:0] rmode, input logic sign,
                                    input logic g, input logic r, input logic s);
    logic lost;
    lost = r | s;
    case (rmode)
      RM_NEAREST: round_up = r & (s | g);  // above half, or tie with odd lsb
      RM_TO_ZERO: round_up = 1'b0;
      RM_TO_INFP: round_up = ~sign & lost;
      RM_TO_INFM: round_up = sign & lost;
      default:    round_up = 1'b0;
    endcase
  endfunction

endpackage

//--- f32_round_path.sv
// float path: align stage with sticky tracking, then round stage
`timescale 1ns/1ps

module f32_round_path (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush_i,
  input  logic                           adv_i,
  input  logic [1:0]                     rmode_i,
  // operand from add or mul, already selected
  input  logic                           f32_rdy_i,
  input  logic                           f32_sign_i,
  input  logic                           f32_sub_zero_i,  // exact-zero subtraction
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]   f32_shr_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]   f32_shl_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_shr_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_shl_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_sh0_i,
  input  logic [fpu_fmt_pkg::FRAC_IN_W-1:0] f32_fract_i,
  input  logic                           f32_inv_i,
  input  logic                           f32_inf_i,
  input  logic                           f32_snan_i,
  input  logic                           f32_qnan_i,
  input  logic                           f32_nan_sign_i,
  // rounded item to the finishing stage
  output logic                           f_vld_o,
  output logic                           f_sign_o,
  output logic [fpu_fmt_pkg::EXP_W-1:0]     f_exp_o,
  output logic [fpu_fmt_pkg::MANT_W:0]      f_mant_o,  // msb is the rounding carry
  output logic                           f_lost_o,
  output logic                           f_inv_o,
  output logic                           f_inf_o,
  output logic                           f_snan_o,
  output logic                           f_qnan_o,
  output logic                           f_nan_sign_o
);

  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  ////////////////////
  // stage 1, align
  ////////////////////

  logic [FRAC_IN_W-1:0] a_sh;      // shifted fraction
  logic [5:0]           a_rpos;    // right shift plus the two tail bits
  logic [FRAC_IN_W-1:0] a_rmask;   // bits lost by the right shift
  logic                 a_rsticky;
  logic                 a_lsticky;
  logic                 a_sticky;
  logic [EXP_W-1:0]     a_exp;
  logic                 a_sign;

  // right shift wins over left
  assign a_sh = (|f32_shr_i) ? (f32_fract_i >> f32_shr_i) : (f32_fract_i << f32_shl_i);

  // everything at or below shr+1 ends up under the round bit
  assign a_rpos    = {1'b0, f32_shr_i} + 6'd2;
  assign a_rmask   = ~({FRAC_IN_W{1'b1}} << a_rpos);
  assign a_rsticky = |(f32_fract_i & a_rmask);

  // left shift pulls the tail up, so fewer bits stay below round
  assign a_lsticky = (f32_shl_i == '0)           ? |f32_fract_i[1:0] :
                     (f32_shl_i == SHIFT_W'(1)) ? f32_fract_i[0]    :
                                                  1'b0;

  assign a_sticky = (|f32_shr_i) ? a_rsticky : a_lsticky;

  assign a_exp = (|f32_shr_i) ? f32_exp_shr_i :
                 (|f32_shl_i) ? f32_exp_shl_i :
                                f32_exp_sh0_i;

  // x - x gives -0 only when rounding toward -inf
  assign a_sign = f32_sub_zero_i ? (rmode_i == RM_TO_INFM) : f32_sign_i;

  logic              s1_vld;
  logic              s1_sign;
  logic [EXP_W-1:0]  s1_exp;
  logic [MANT_W-1:0] s1_mant;
  logic [1:0]        s1_rs;   // {round, sticky}
  logic              s1_inv;
  logic              s1_inf;
  logic              s1_snan;
  logic              s1_qnan;
  logic              s1_nan_sign;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign     <= a_sign;
      s1_exp      <= a_exp;
      s1_mant     <= a_sh[FRAC_IN_W-2 -: MANT_W];  // bit 27 is free after align
      s1_rs       <= {a_sh[2], a_sticky};
      s1_inv      <= f32_inv_i;
      s1_inf      <= f32_inf_i;
      s1_snan     <= f32_snan_i;
      s1_qnan     <= f32_qnan_i;
      s1_nan_sign <= f32_nan_sign_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) s1_vld <= 1'b0;
    else if (adv_i)     s1_vld <= f32_rdy_i;
  end

  ////////////////////
  // stage 2, round
  ////////////////////

  logic r_up;

  assign r_up = round_up(rmode_i, s1_sign, s1_mant[0], s1_rs[1], s1_rs[0]);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      f_sign_o     <= s1_sign;
      f_exp_o      <= s1_exp;
      f_mant_o     <= {1'b0, s1_mant} + {{MANT_W{1'b0}}, r_up};  // carry kept in msb
      f_lost_o     <= |s1_rs;
      f_inv_o      <= s1_inv;
      f_inf_o      <= s1_inf;
      f_snan_o     <= s1_snan;
      f_qnan_o     <= s1_qnan;
      f_nan_sign_o <= s1_nan_sign;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) f_vld_o <= 1'b0;
    else if (adv_i)     f_vld_o <= s1_vld;
  end

endmodule

//--- i32_round_path.sv
// integer path: f2i input register stage, then magnitude round stage
`timescale 1ns/1ps

module i32_round_path (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  input  logic [1:0]                      rmode_i,
  // f2i magnitude with its round and sticky bits
  input  logic                            i32_rdy_i,
  input  logic                            i32_sign_i,
  input  logic [fpu_fmt_pkg::WORD_W-1:0]  i32_mag_i,
  input  logic [1:0]                      i32_rs_i,
  input  logic                            i32_ovf_i,
  input  logic                            i32_snan_i,
  // rounded magnitude to the finishing stage
  output logic                            i_vld_o,
  output logic                            i_sign_o,
  output logic [fpu_fmt_pkg::WORD_W-1:0]  i_mag_o,
  output logic                            i_lost_o,
  output logic                            i_ovf_o,
  output logic                            i_snan_o
);

  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  ////////////////////
  // stage 1, input
  ////////////////////

  // matches the float align latency
  logic              s1_vld;
  logic              s1_sign;
  logic [WORD_W-1:0] s1_mag;
  logic [1:0]        s1_rs;
  logic              s1_ovf;
  logic              s1_snan;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign <= i32_sign_i;
      s1_mag  <= i32_mag_i;
      s1_rs   <= i32_rs_i;
      s1_ovf  <= i32_ovf_i;
      s1_snan <= i32_snan_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) s1_vld <= 1'b0;
    else if (adv_i)     s1_vld <= i32_rdy_i;
  end

  ////////////////////
  // stage 2, round
  ////////////////////

  logic r_up;

  assign r_up = round_up(rmode_i, s1_sign, s1_mag[0], s1_rs[1], s1_rs[0]); // lsb as guard

  always_ff @(posedge clk) begin
    if (adv_i) begin
      i_sign_o <= s1_sign;
      i_mag_o  <= s1_mag + {{(WORD_W-1){1'b0}}, r_up};  // may carry into bit 31
      i_lost_o <= |s1_rs;
      i_ovf_o  <= s1_ovf;
      i_snan_o <= s1_snan;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) i_vld_o <= 1'b0;
    else if (adv_i)     i_vld_o <= s1_vld;
  end

endmodule

//--- rnd_finish.sv
// finishing stage: float and integer packing, special cases, flags, output registers
`timescale 1ns/1ps

module rnd_finish (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush_i,
  input  logic                             adv_i,
  // float path
  input  logic                             f_vld_i,
  input  logic                             f_sign_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]    f_exp_i,
  input  logic [fpu_fmt_pkg::MANT_W:0]     f_mant_i,
  input  logic                             f_lost_i,
  input  logic                             f_inv_i,
  input  logic                             f_inf_i,
  input  logic                             f_snan_i,
  input  logic                             f_qnan_i,
  input  logic                             f_nan_sign_i,
  // integer path
  input  logic                             i_vld_i,
  input  logic                             i_sign_i,
  input  logic [fpu_fmt_pkg::WORD_W-1:0]   i_mag_i,
  input  logic                             i_lost_i,
  input  logic                             i_ovf_i,
  input  logic                             i_snan_i,
  // packed result
  output logic [fpu_fmt_pkg::WORD_W-1:0]   result_o,
  output logic                             valid_o,
  output logic [fpu_ctrl_pkg::FLAG_W-1:0]  flags_o
);

  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  ////////////////////
  // float result
  ////////////////////

  logic              f_carry;
  logic [EXP_W-1:0]  f_exp_n;
  logic [MANT_W-1:0] f_mant_n;
  logic              f_dn;    // hidden bit clear
  logic              f_zero;
  logic              f_big;   // past largest finite exponent

  assign f_carry  = f_mant_i[MANT_W];  // rounding overflowed 1.111..
  assign f_exp_n  = f_exp_i + {{(EXP_W-1){1'b0}}, f_carry};
  assign f_mant_n = f_carry ? f_mant_i[MANT_W:1] : f_mant_i[MANT_W-1:0];
  assign f_dn     = ~f_mant_n[MANT_W-1];
  assign f_zero   = ~(|f_mant_n);
  assign f_big    = f_exp_n > EXP_MAX;

  fpu_word_u         f_word;
  logic [FLAG_W-1:0] f_flags;

  always_comb begin
    f_word  = '0;
    f_flags = '0;
    if (f_snan_i || f_qnan_i) begin
      // nan in, quiet nan out
      f_word.f.sign              = f_nan_sign_i;
      {f_word.f.exp, f_word.f.frac} = QNAN_BODY;
      f_flags[FLG_QNF]           = 1'b1;
      f_flags[FLG_IVF]           = 1'b1;
      f_flags[FLG_SNF]           = f_snan_i;
    end else if (f_inv_i) begin
      f_word.f.sign              = f_sign_i;
      {f_word.f.exp, f_word.f.frac} = SNAN_BODY;
      f_flags[FLG_SNF]           = 1'b1;
      f_flags[FLG_IVF]           = 1'b1;
    end else if (f_big || f_inf_i) begin
      f_word.f.sign              = f_sign_i;
      {f_word.f.exp, f_word.f.frac} = INF_BODY;
      f_flags[FLG_INF]           = 1'b1;
      f_flags[FLG_OVF]           = ~f_inf_i;             // only a real overflow
      f_flags[FLG_IXF]           = f_lost_i | ~f_inf_i;
    end else begin
      // denormal / zero gets exponent field 0, else normal
      f_word.f.sign    = f_sign_i;
      f_word.f.exp     = f_dn ? 8'd0 : f_exp_n[7:0];
      f_word.f.frac    = f_mant_n[MANT_W-2:0];
      f_flags[FLG_ZF]  = f_zero;
      f_flags[FLG_UNF] = f_zero & f_lost_i;
      f_flags[FLG_IXF] = f_lost_i;
    end
  end

  ////////////////////
  // integer result
  ////////////////////

  logic              i_sat;   // out of int32 range
  logic [WORD_W-1:0] i_neg;   // two's complement when negative
  logic              i_zero;

  assign i_sat  = (~i_sign_i & i_mag_i[WORD_W-1]) | i_ovf_i;
  assign i_neg  = (i_mag_i ^ {WORD_W{i_sign_i}}) + {{(WORD_W-1){1'b0}}, i_sign_i};
  assign i_zero = ~i_sat & ~(|i_neg);

  fpu_word_u         i_word;
  logic [FLAG_W-1:0] i_flags;

  always_comb begin
    i_word  = '0;
    i_flags = '0;
    if (i_sat) i_word.i = i_sign_i ? 32'sh8000_0000 : 32'sh7FFF_FFFF; // clamp
    else       i_word.i = $signed(i_neg);
    i_flags[FLG_ZF]  = i_zero;
    i_flags[FLG_UNF] = i_zero & i_lost_i;
    i_flags[FLG_IXF] = i_lost_i;
    i_flags[FLG_SNF] = i_snan_i;
    i_flags[FLG_IVF] = i_sat | i_snan_i;
  end

  ////////////////////
  // output registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      flags_o  <= '0;
    end else if (adv_i) begin
      valid_o <= f_vld_i | i_vld_i;  // never both
      if (i_vld_i) begin
        result_o <= i_word;
        flags_o  <= i_flags;
      end else if (f_vld_i) begin
        result_o <= f_word;
        flags_o  <= f_flags;
      end else begin
        result_o <= '0;  // bubble leaves zeros
        flags_o  <= '0;
      end
    end
  end

endmodule

//--- fpu_rnd_top.sv
// rounding back end top: float path, integer path and finishing stage
`timescale 1ns/1ps

module fpu_rnd_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush_i,
  input  logic                             adv_i,
  input  logic [1:0]                       rmode_i,
  // float operand
  input  logic                             f32_rdy_i,
  input  logic                             f32_sign_i,
  input  logic                             f32_sub_zero_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]   f32_shr_i,
  input  logic [fpu_fmt_pkg::SHIFT_W-1:0]   f32_shl_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_shr_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_shl_i,
  input  logic [fpu_fmt_pkg::EXP_W-1:0]     f32_exp_sh0_i,
  input  logic [fpu_fmt_pkg::FRAC_IN_W-1:0] f32_fract_i,
  input  logic                             f32_inv_i,
  input  logic                             f32_inf_i,
  input  logic                             f32_snan_i,
  input  logic                             f32_qnan_i,
  input  logic                             f32_nan_sign_i,
  // integer operand
  input  logic                             i32_rdy_i,
  input  logic                             i32_sign_i,
  input  logic [fpu_fmt_pkg::WORD_W-1:0]   i32_mag_i,
  input  logic [1:0]                       i32_rs_i,
  input  logic                             i32_ovf_i,
  input  logic                             i32_snan_i,
  // result
  output logic [fpu_fmt_pkg::WORD_W-1:0]   result_o,
  output logic                             valid_o,
  output logic [fpu_ctrl_pkg::FLAG_W-1:0]  flags_o
);

  import fpu_fmt_pkg::*;

  // float path to finish
  logic f_vld, f_sign, f_lost, f_inv, f_inf, f_snan, f_qnan, f_nan_sign;
  logic [EXP_W-1:0] f_exp;
  logic [MANT_W:0]  f_mant;
  // integer path to finish
  logic i_vld, i_sign, i_lost, i_ovf, i_snan;
  logic [WORD_W-1:0] i_mag;

  f32_round_path u_f32 (
    .clk, .rst, .flush_i, .adv_i, .rmode_i,
    .f32_rdy_i, .f32_sign_i, .f32_sub_zero_i, .f32_shr_i, .f32_shl_i,
    .f32_exp_shr_i, .f32_exp_shl_i, .f32_exp_sh0_i, .f32_fract_i,
    .f32_inv_i, .f32_inf_i, .f32_snan_i, .f32_qnan_i, .f32_nan_sign_i,
    .f_vld_o(f_vld), .f_sign_o(f_sign), .f_exp_o(f_exp), .f_mant_o(f_mant),
    .f_lost_o(f_lost), .f_inv_o(f_inv), .f_inf_o(f_inf), .f_snan_o(f_snan),
    .f_qnan_o(f_qnan), .f_nan_sign_o(f_nan_sign)
  );

  i32_round_path u_i32 (
    .clk, .rst, .flush_i, .adv_i, .rmode_i,
    .i32_rdy_i, .i32_sign_i, .i32_mag_i, .i32_rs_i, .i32_ovf_i, .i32_snan_i,
    .i_vld_o(i_vld), .i_sign_o(i_sign), .i_mag_o(i_mag), .i_lost_o(i_lost),
    .i_ovf_o(i_ovf), .i_snan_o(i_snan)
  );

  rnd_finish u_fin (
    .clk, .rst, .flush_i, .adv_i,
    .f_vld_i(f_vld), .f_sign_i(f_sign), .f_exp_i(f_exp), .f_mant_i(f_mant),
    .f_lost_i(f_lost), .f_inv_i(f_inv), .f_inf_i(f_inf), .f_snan_i(f_snan),
    .f_qnan_i(f_qnan), .f_nan_sign_i(f_nan_sign),
    .i_vld_i(i_vld), .i_sign_i(i_sign), .i_mag_i(i_mag), .i_lost_i(i_lost),
    .i_ovf_i(i_ovf), .i_snan_i(i_snan),
    .result_o, .valid_o, .flags_o
  );

endmodule

//--- fpu_rnd_asserts.sv
// concurrent checks on operand exclusivity, reset, stall hold and idle flags
`timescale 1ns/1ps

module fpu_rnd_asserts (
  input logic                             clk,
  input logic                             rst,
  input logic                             flush_i,
  input logic                             adv_i,
  input logic                             f32_rdy_i,
  input logic                             i32_rdy_i,
  input logic [fpu_fmt_pkg::WORD_W-1:0]   result_i,
  input logic                             valid_i,
  input logic [fpu_ctrl_pkg::FLAG_W-1:0]  flags_i
);

  // upstream offers one operand per cycle
  one_source: assert property (@(posedge clk) !(f32_rdy_i && i32_rdy_i))
    else $error("float and integer operands offered in the same cycle");

  reset_clears: assert property (@(posedge clk) rst |=> !valid_i)
    else $error("valid high in the cycle after reset");

  // stall without flush freezes everything
  hold_stall: assert property (@(posedge clk) disable iff (rst)
      (!adv_i && !flush_i) |=> ($stable(result_i) && $stable(valid_i) && $stable(flags_i)))
    else $error("outputs changed while the pipe was stalled");

  idle_flags: assert property (@(posedge clk) disable iff (rst) !valid_i |-> flags_i == '0)
    else $error("flags set without a valid result");

endmodule

//--- tb_fpu_rnd.sv
// testbench clock, reset, lfsr stimulus, reference model and output checks for the rounding back end
`timescale 1ns/1ps

module tb_fpu_rnd;

  import fpu_fmt_pkg::*;
  import fpu_ctrl_pkg::*;

  localparam int K_IDLE   = 0;
  localparam int K_NORM   = 1;
  localparam int K_SPEC   = 2;
  localparam int K_INT    = 3;
  localparam int N_PER    = 40;    // items per kind and mode
  localparam int N_MIX    = 400;   // mixed cycles at the end
  localparam int N_ITEMS  = 4 * 3 * N_PER + N_MIX;
  localparam int CYC_ITEM = 4;     // loose bound that covers stalls and drains
  localparam int WATCH_NS = (N_ITEMS * CYC_ITEM + 100) * 20;

  logic                 clk, rst, flush_i, adv_i;
  logic [1:0]           rmode_i;
  logic                 f32_rdy_i, f32_sign_i, f32_sub_zero_i;
  logic [SHIFT_W-1:0]   f32_shr_i, f32_shl_i;
  logic [EXP_W-1:0]     f32_exp_shr_i, f32_exp_shl_i, f32_exp_sh0_i;
  logic [FRAC_IN_W-1:0] f32_fract_i;
  logic                 f32_inv_i, f32_inf_i, f32_snan_i, f32_qnan_i, f32_nan_sign_i;
  logic                 i32_rdy_i, i32_sign_i, i32_ovf_i, i32_snan_i;
  logic [WORD_W-1:0]    i32_mag_i;
  logic [1:0]           i32_rs_i;
  logic [WORD_W-1:0]    result_o;
  logic                 valid_o;
  logic [FLAG_W-1:0]    flags_o;

  fpu_rnd_top dut0 (.*);

  bind fpu_rnd_top fpu_rnd_asserts u_chk (
    .clk, .rst, .flush_i, .adv_i, .f32_rdy_i, .i32_rdy_i,
    .result_i(result_o), .valid_i(valid_o), .flags_i(flags_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  initial begin
    #(WATCH_NS);
    $display("timeout: the run did not get through all items in the expected time");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // random bits
  ////////////////////

  logic [31:0] lfsr_q;

  // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        nb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      nb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], nb};
      r      = {r[30:0], nb};
    end
    return r;
  endfunction

  function automatic logic coin();
    logic [31:0] b;
    b = take_bits(1);
    return b[0];
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  logic              vld_q[$];   // pipe contents with the oldest first
  logic [31:0]       word_q[$];
  logic [FLAG_W-1:0] flag_q[$];
  logic              cur_vld;    // what the outputs should show now
  logic [31:0]       cur_word;
  logic [FLAG_W-1:0] cur_flags;
  logic              cur_clr;    // outputs cleared by reset or flush
  logic [1:0]        mode_sel;

  function automatic logic incr_needed(input logic [1:0] mode, input logic sgn,
                                       input logic lsb, input logic r, input logic s);
    case (mode)
      RM_NEAREST: return r & (s | lsb);  // ties go to even
      RM_TO_INFP: return ~sgn & (r | s);
      RM_TO_INFM: return sgn & (r | s);
      default:    return 1'b0;           // truncate
    endcase
  endfunction

  // float item from the current input fields
  function automatic void model_float(output fpu_word_u w, output logic [FLAG_W-1:0] fl);
    logic [59:0]          wide;
    logic [FRAC_IN_W-1:0] sh;
    logic [EXP_W-1:0]     e;
    logic [MANT_W:0]      m;
    logic                 s, sgn, up, lost, zero;
    w  = '0;
    fl = '0;
    if (|f32_shr_i) begin
      wide = {f32_fract_i, 32'd0} >> f32_shr_i;
      sh   = wide[59:32];
      s    = |wide[33:0];  // everything that lands below the round bit
      e    = f32_exp_shr_i;
    end else begin
      sh = f32_fract_i << f32_shl_i;
      s  = |sh[1:0];
      e  = (|f32_shl_i) ? f32_exp_shl_i : f32_exp_sh0_i;
    end
    sgn  = f32_sub_zero_i ? (rmode_i == RM_TO_INFM) : f32_sign_i;
    lost = sh[2] | s;
    up   = incr_needed(rmode_i, sgn, sh[3], sh[2], s);
    m    = {1'b0, sh[26:3]} + {{MANT_W{1'b0}}, up};
    if (m[MANT_W]) begin
      m = {1'b0, m[MANT_W:1]};  // carry out renormalizes
      e = e + 10'd1;
    end
    zero = ~|m[MANT_W-1:0];
    if (f32_snan_i || f32_qnan_i) begin
      w.f.sign          = f32_nan_sign_i;
      {w.f.exp, w.f.frac} = QNAN_BODY;
      fl[FLG_QNF]       = 1'b1;
      fl[FLG_IVF]       = 1'b1;
      fl[FLG_SNF]       = f32_snan_i;
    end else if (f32_inv_i) begin
      w.f.sign          = sgn;
      {w.f.exp, w.f.frac} = SNAN_BODY;
      fl[FLG_SNF]       = 1'b1;
      fl[FLG_IVF]       = 1'b1;
    end else if (e > EXP_MAX || f32_inf_i) begin
      w.f.sign          = sgn;
      {w.f.exp, w.f.frac} = INF_BODY;
      fl[FLG_INF]       = 1'b1;
      fl[FLG_OVF]       = ~f32_inf_i;
      fl[FLG_IXF]       = lost | ~f32_inf_i;
    end else begin
      w.f.sign    = sgn;
      w.f.exp     = m[MANT_W-1] ? e[7:0] : 8'd0;  // denormal or zero
      w.f.frac    = m[MANT_W-2:0];
      fl[FLG_ZF]  = zero;
      fl[FLG_UNF] = zero & lost;
      fl[FLG_IXF] = lost;
    end
  endfunction

  // integer item as two's complement with clamping
  function automatic void model_int(output fpu_word_u w, output logic [FLAG_W-1:0] fl);
    logic [WORD_W-1:0] m;
    logic              up, lost, sat;
    w    = '0;
    fl   = '0;
    lost = |i32_rs_i;
    up   = incr_needed(rmode_i, i32_sign_i, i32_mag_i[0], i32_rs_i[1], i32_rs_i[0]);
    m    = i32_mag_i + {{(WORD_W-1){1'b0}}, up};
    sat  = (~i32_sign_i & m[WORD_W-1]) | i32_ovf_i;
    if (sat)             w.i = i32_sign_i ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
    else if (i32_sign_i) w.i = -$signed(m);
    else                 w.i = $signed(m);
    fl[FLG_ZF]  = ~sat & (w.i == 32'sd0);
    fl[FLG_UNF] = fl[FLG_ZF] & lost;
    fl[FLG_IXF] = lost;
    fl[FLG_SNF] = i32_snan_i;
    fl[FLG_IVF] = sat | i32_snan_i;
  endfunction

  task automatic reset_model();
    vld_q.delete();
    word_q.delete();
    flag_q.delete();
    repeat (2) begin  // two bubbles ahead of any new item
      vld_q.push_back(1'b0);
      word_q.push_back('0);
      flag_q.push_back('0);
    end
    cur_vld   = 1'b0;
    cur_word  = '0;
    cur_flags = '0;
    cur_clr   = 1'b1;
  endtask

  // one clock edge of the model fed by the inputs the dut samples
  task automatic model_edge();
    fpu_word_u         w;
    logic [FLAG_W-1:0] fl;
    logic              v;
    if (rst || flush_i) begin
      reset_model();
    end else if (adv_i) begin
      v  = f32_rdy_i | i32_rdy_i;
      w  = '0;
      fl = '0;
      if (f32_rdy_i)      model_float(w, fl);
      else if (i32_rdy_i) model_int(w, fl);
      vld_q.push_back(v);
      word_q.push_back(w);
      flag_q.push_back(fl);
      cur_vld   = vld_q.pop_front();
      cur_word  = word_q.pop_front();
      cur_flags = flag_q.pop_front();
      cur_clr   = 1'b0;
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
      $display("STATUS: FAIL");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic check_outputs();
    check_val("valid_o", 32'(valid_o), 32'(cur_vld));
    check_val("flags_o", 32'(flags_o), 32'(cur_flags));
    if (cur_vld || cur_clr) check_val("result_o", result_o, cur_word);
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_float(input logic special);
    logic [FRAC_IN_W-1:0] fr;
    logic [SHIFT_W-1:0]   shr, shl;
    logic [EXP_W-1:0]     e_r, e_l, e_0;
    logic                 inv, inf, sn, qn, sz;
    fr  = {2'b01, 26'(take_bits(26))};  // hidden bit at 26
    shr = '0;
    shl = '0;
    case (2'(take_bits(2)))
      2'd1: shr = SHIFT_W'(take_bits(5));
      2'd2: begin
        shl = SHIFT_W'(take_bits(3));
        fr  = fr >> shl;  // leading zeros for the left shift to remove
      end
      default: ;
    endcase
    e_r = 10'd60 + EXP_W'(take_bits(7));
    e_l = 10'd60 + EXP_W'(take_bits(7));
    e_0 = 10'd60 + EXP_W'(take_bits(7));
    inv = 1'b0;
    inf = 1'b0;
    sn  = 1'b0;
    qn  = 1'b0;
    sz  = 1'b0;
    if (special) begin
      case (3'(take_bits(3)))
        3'd0: begin  // around the top exponent
          shr = '0;
          shl = '0;
          e_0 = 10'd250 + EXP_W'(take_bits(3));
          if (coin()) fr = 28'h7FF_FFFF;  // rounds up into a carry
        end
        3'd1: fr = FRAC_IN_W'(take_bits(20));  // hidden bit clear
        3'd2: inf = 1'b1;
        3'd3: inv = 1'b1;
        3'd4: sn  = 1'b1;
        3'd5: qn  = 1'b1;
        3'd6: begin  // x - x
          sz  = 1'b1;
          fr  = '0;
          shr = '0;
          shl = '0;
        end
        default: begin  // tiny and mostly shifted out
          fr  = FRAC_IN_W'(take_bits(3));
          shr = SHIFT_W'(take_bits(5));
        end
      endcase
    end
    f32_rdy_i      <= 1'b1;
    i32_rdy_i      <= 1'b0;
    f32_sign_i     <= coin();
    f32_sub_zero_i <= sz;
    f32_shr_i      <= shr;
    f32_shl_i      <= shl;
    f32_exp_shr_i  <= e_r;
    f32_exp_shl_i  <= e_l;
    f32_exp_sh0_i  <= e_0;
    f32_fract_i    <= fr;
    f32_inv_i      <= inv;
    f32_inf_i      <= inf;
    f32_snan_i     <= sn;
    f32_qnan_i     <= qn;
    f32_nan_sign_i <= coin();
  endtask

  task automatic drive_int();
    logic [WORD_W-1:0] mag;
    case (2'(take_bits(2)))
      2'd0:    mag = WORD_W'(take_bits(2));   // zero and near zero
      2'd1:    mag = 32'h7FFF_FFFF;           // carry into bit 31 when rounded up
      default: mag = {1'b0, 31'(take_bits(31))};
    endcase
    f32_rdy_i  <= 1'b0;
    i32_rdy_i  <= 1'b1;
    i32_sign_i <= coin();
    i32_mag_i  <= mag;
    i32_rs_i   <= 2'(take_bits(2));
    i32_ovf_i  <= (4'(take_bits(4)) == 4'd0);
    i32_snan_i <= (4'(take_bits(4)) == 4'd0);
  endtask

  // model the edge, drive the next inputs, check at the falling edge
  task automatic cycle_step(input int kind, input logic adv, input logic fl);
    @(posedge clk);
    model_edge();
    case (kind)
      K_NORM:  drive_float(1'b0);
      K_SPEC:  drive_float(1'b1);
      K_INT:   drive_int();
      default: begin
        f32_rdy_i <= 1'b0;
        i32_rdy_i <= 1'b0;
      end
    endcase
    adv_i   <= adv;
    flush_i <= fl;
    rmode_i <= mode_sel;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic drain();
    repeat (4) cycle_step(K_IDLE, 1'b1, 1'b0);
  endtask

  initial begin
    lfsr_q         = 32'd89034;
    mode_sel       = RM_NEAREST;
    rst            = 1'b1;
    flush_i        = 1'b0;
    adv_i          = 1'b0;
    rmode_i        = RM_NEAREST;
    f32_rdy_i      = 1'b0;
    f32_sign_i     = 1'b0;
    f32_sub_zero_i = 1'b0;
    f32_shr_i      = '0;
    f32_shl_i      = '0;
    f32_exp_shr_i  = '0;
    f32_exp_shl_i  = '0;
    f32_exp_sh0_i  = '0;
    f32_fract_i    = '0;
    f32_inv_i      = 1'b0;
    f32_inf_i      = 1'b0;
    f32_snan_i     = 1'b0;
    f32_qnan_i     = 1'b0;
    f32_nan_sign_i = 1'b0;
    i32_rdy_i      = 1'b0;
    i32_sign_i     = 1'b0;
    i32_mag_i      = '0;
    i32_rs_i       = '0;
    i32_ovf_i      = 1'b0;
    i32_snan_i     = 1'b0;
    reset_model();

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    cycle_step(K_IDLE, 1'b1, 1'b0);  // outputs still cleared by reset

    // every kind in every rounding mode with the pipe drained between modes
    for (int m = 0; m < 4; m++) begin
      mode_sel = 2'(m);
      repeat (N_PER) cycle_step(K_NORM, 1'b1, 1'b0);
      repeat (N_PER) cycle_step(K_SPEC, 1'b1, 1'b0);
      repeat (N_PER) cycle_step(K_INT, 1'b1, 1'b0);
      drain();
    end

    // mixed traffic with stalls and two flushes
    mode_sel = 2'(take_bits(2));
    for (int i = 0; i < N_MIX; i++) begin
      cycle_step(int'(take_bits(2)), coin() | coin(),
                 (i == N_MIX / 4) || (i == 3 * N_MIX / 4));
    end
    drain();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- vlog.f
fpu_fmt_pkg.sv
fpu_ctrl_pkg.sv
f32_round_path.sv
i32_round_path.sv
rnd_finish.sv
fpu_rnd_top.sv
fpu_rnd_asserts.sv
tb_fpu_rnd.sv

//--- Makefile
# Verilator build and run of the rounding back end testbench

SRCS := $(shell cat vlog.f)
BIN  := obj_dir/Vtb_fpu_rnd

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module tb_fpu_rnd -o Vtb_fpu_rnd

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
